// ==== Makefile ====
VERILATOR := verilator
TOP       := uart_cmd_bridge_tb
FILELIST  := uart_cmd_bridge.f
VFLAGS    := --timing --assert --top-module $(TOP) -f $(FILELIST)
SIMFLAGS  := +verilator+error+limit+100
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary --Mdir obj_dir $(VFLAGS)
	./obj_dir/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/uart_cmd_bridge.sv ====
`default_nettype none
`timescale 1ns/1ns

module uart_cmd_bridge (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire  uart_cmd_pkg::uart_cmd_t        cmd_in,
  input  wire                                  cmd_vld,
  output logic                                 cmd_rdy,
  input  wire                                  rx,
  output logic                                 tx,
  output logic [uart_cmd_pkg::DATA_WIDTH-1:0]  read_data,
  output logic                                 read_vld,
  output logic                                 read_err
);

  import uart_cmd_pkg::*;

  logic [DATA_WIDTH-1:0] tx_byte;
  logic                  tx_req;
  logic                  tx_ack;
  logic [DATA_WIDTH-1:0] rx_byte;
  logic                  rx_bad;
  logic                  rx_req;
  logic                  rx_ack;

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_byte   (tx_byte),
    .tx_req    (tx_req),
    .tx_ack    (tx_ack),
    .rx_byte   (rx_byte),
    .rx_bad    (rx_bad),
    .rx_req    (rx_req),
    .rx_ack    (rx_ack),
    .read_data (read_data),
    .read_vld  (read_vld),
    .read_err  (read_err)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_byte (tx_byte),
    .tx_req  (tx_req),
    .tx_ack  (tx_ack),
    .tx      (tx)
  );

  uart_rx u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_byte (rx_byte),
    .rx_bad  (rx_bad),
    .rx_req  (rx_req),
    .rx_ack  (rx_ack)
  );

endmodule

`default_nettype wire

// ==== design/uart_cmd_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ns

module uart_cmd_ctrl (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire  uart_cmd_pkg::uart_cmd_t        cmd_in,
  input  wire                                  cmd_vld,
  output logic                                 cmd_rdy,
  output logic [uart_cmd_pkg::DATA_WIDTH-1:0]  tx_byte,
  output logic                                 tx_req,
  input  wire                                  tx_ack,
  input  wire  [uart_cmd_pkg::DATA_WIDTH-1:0]  rx_byte,
  input  wire                                  rx_bad,
  input  wire                                  rx_req,
  output logic                                 rx_ack,
  output logic [uart_cmd_pkg::DATA_WIDTH-1:0]  read_data,
  output logic                                 read_vld,
  output logic                                 read_err
);

  import uart_cmd_pkg::*;

  logic [2:0]       state;
  uart_cmd_t        cmd_q;
  logic [GAP_W-1:0] gap_cnt;
  logic             accept;

  // cmd_rdy is only high in idle.
  assign accept = cmd_vld && cmd_rdy;

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd_in;
    end
  end

  // Address byte carries rw in its MSB; only writes send a second byte.
  assign tx_byte = (state == ST_SEND_DATA) ? cmd_q.wr.data
                                           : {cmd_q.rd.rw, cmd_q.rd.addr};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= ST_IDLE;
      cmd_rdy   <= 1'b1;
      tx_req    <= 1'b0;
      rx_ack    <= 1'b0;
      gap_cnt   <= '0;
      read_data <= '0;
      read_vld  <= 1'b0;
      read_err  <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;

      // Every receiver frame is acknowledged; unsolicited ones are dropped.
      if (rx_req && !rx_ack)
      begin
        rx_ack <= 1'b1;
      end
      else if (!rx_req && rx_ack)
      begin
        rx_ack <= 1'b0;
      end

      case (state)
        ST_IDLE:
        begin
          if (accept)
          begin
            cmd_rdy <= 1'b0;
            tx_req  <= 1'b1;
            state   <= ST_SEND_ADDR;
          end
        end
        ST_SEND_ADDR:
        begin
          if (tx_ack)
          begin
            tx_req  <= 1'b0;
            gap_cnt <= '0;
            state   <= cmd_q.wr.rw ? ST_GAP : ST_WAIT_REPLY;
          end
        end
        ST_GAP:
        begin
          if (gap_cnt == GAP_W'(GAP_CYCLES - 1) && !tx_ack)
          begin
            tx_req <= 1'b1;
            state  <= ST_SEND_DATA;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        ST_SEND_DATA:
        begin
          if (tx_ack)
          begin
            tx_req  <= 1'b0;
            cmd_rdy <= 1'b1;    // Write finished.
            state   <= ST_IDLE;
          end
        end
        ST_WAIT_REPLY:
        begin
          if (rx_req && !rx_ack)
          begin
            read_data <= rx_byte;
            read_err  <= rx_bad;
            state     <= ST_PRESENT;
          end
        end
        ST_PRESENT:
        begin
          read_vld <= 1'b1;
          cmd_rdy  <= 1'b1;
          state    <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

  localparam int CMD_WIDTH    = 16;
  localparam int DATA_WIDTH   = 8;
  localparam int CLKS_PER_BIT = 16;
  localparam int GAP_CYCLES   = 32;    // Idle cycles between write bytes.
  localparam int FRAME_BITS   = 11;    // Start, eight data, parity, stop.

  localparam int BAUD_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_W  = $clog2(FRAME_BITS);
  localparam int GAP_W  = $clog2(GAP_CYCLES);

  localparam logic [2:0] ST_IDLE       = 3'd0;
  localparam logic [2:0] ST_SEND_ADDR  = 3'd1;
  localparam logic [2:0] ST_GAP        = 3'd2;
  localparam logic [2:0] ST_SEND_DATA  = 3'd3;
  localparam logic [2:0] ST_WAIT_REPLY = 3'd4;
  localparam logic [2:0] ST_PRESENT    = 3'd5;

  // Odd parity: the parity bit is the inverted XOR of the data bits, so
  // data plus parity always carry an odd number of ones.
  function automatic logic odd_parity(input logic [DATA_WIDTH-1:0] data);
    return ~^data;
  endfunction

  typedef struct packed {
    logic                              rw;    // Set for a write.
    logic [CMD_WIDTH-DATA_WIDTH-2:0]   addr;
    logic [DATA_WIDTH-1:0]             data;
  } cmd_wr_t;

  typedef struct packed {
    logic                              rw;    // Clear for a read.
    logic [CMD_WIDTH-DATA_WIDTH-2:0]   addr;
    logic [DATA_WIDTH-1:0]             spare;
  } cmd_rd_t;

  // Upper byte goes out first, so the remote side sees rw as its MSB.
  typedef union packed {
    cmd_wr_t wr;
    cmd_rd_t rd;
  } uart_cmd_t;

endpackage

`default_nettype wire

// ==== design/uart_rx.sv ====
`default_nettype none
`timescale 1ns/1ns

module uart_rx (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  rx,
  output logic [uart_cmd_pkg::DATA_WIDTH-1:0]  rx_byte,
  output logic                                 rx_bad,
  output logic                                 rx_req,
  input  wire                                  rx_ack
);

  import uart_cmd_pkg::*;

  logic              rx_meta;
  logic              rx_sync;
  logic              rx_prev;
  logic              busy;
  logic [BAUD_W-1:0] baud_cnt;
  logic [BIT_W-1:0]  bit_idx;
  logic              par_bit;
  logic              start_edge;
  logic              mid_bit;
  logic              bit_end;

  assign start_edge = rx_prev & ~rx_sync;
  assign mid_bit    = busy && (baud_cnt == BAUD_W'(CLKS_PER_BIT / 2 - 1));
  assign bit_end    = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      par_bit  <= 1'b0;
      rx_bad   <= 1'b0;
      rx_req   <= 1'b0;
    end
    else if (rx_req)
    begin
      if (rx_ack)
      begin
        rx_req <= 1'b0;    // Line ignored until here.
      end
    end
    else if (busy)
    begin
      baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
      if (mid_bit)
      begin
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == '0 && rx_sync)
        begin
          busy <= 1'b0;    // Glitch, not a start bit.
        end
        else if (bit_idx == BIT_W'(DATA_WIDTH + 1))
        begin
          par_bit <= rx_sync;
        end
        else if (bit_idx == BIT_W'(FRAME_BITS - 1))
        begin
          busy   <= 1'b0;
          rx_req <= 1'b1;
          rx_bad <= (par_bit != odd_parity(rx_byte)) | ~rx_sync;
        end
      end
    end
    else if (start_edge)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
  end

  // Data bits arrive LSB first.
  always_ff @(posedge clk)
  begin
    if (mid_bit && bit_idx >= BIT_W'(1) && bit_idx <= BIT_W'(DATA_WIDTH))
    begin
      rx_byte <= {rx_sync, rx_byte[DATA_WIDTH-1:1]};
    end
  end

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
`default_nettype none
`timescale 1ns/1ns

module uart_tx (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire  [uart_cmd_pkg::DATA_WIDTH-1:0]  tx_byte,
  input  wire                                  tx_req,
  output logic                                 tx_ack,
  output logic                                 tx
);

  import uart_cmd_pkg::*;

  logic                  busy;
  logic [BAUD_W-1:0]     baud_cnt;
  logic [BIT_W-1:0]      bit_idx;
  logic [FRAME_BITS-1:0] shreg;
  logic                  bit_end;

  assign bit_end = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

  // Line follows the low end of the frame register.
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      shreg    <= '1;    // Idle line is high.
      tx_ack   <= 1'b0;
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        baud_cnt <= '0;
        shreg    <= {1'b1, shreg[FRAME_BITS-1:1]};
        if (bit_idx == BIT_W'(FRAME_BITS - 1))
        begin
          busy   <= 1'b0;    // Stop bit done.
          tx_ack <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
    else if (tx_ack)
    begin
      if (!tx_req)
      begin
        tx_ack <= 1'b0;    // Closes the four-phase cycle.
      end
    end
    else if (tx_req)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      shreg    <= {1'b1, odd_parity(tx_byte), tx_byte, 1'b0};
    end
  end

endmodule

`default_nettype wire

// ==== tests/uart_cmd_bridge_checker.sv ====
`default_nettype none
`timescale 1ns/1ns

module uart_cmd_bridge_checker (
  input wire clk,
  input wire rst_n,
  input wire cmd_vld,
  input wire cmd_rdy,
  input wire tx,
  input wire read_vld
);

  int fail_count;    // Read by the testbench at the end.

  assert property (@(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld)
  else
  begin
    $error("read_vld stayed high for two cycles");
    fail_count++;
  end

  assert property (@(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> !cmd_rdy)
  else
  begin
    $error("cmd_rdy still high after an accepted command");
    fail_count++;
  end

  // Line must be idle whenever a new command can be taken.
  assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
  else
  begin
    $error("tx low while cmd_rdy is high");
    fail_count++;
  end

endmodule

bind uart_cmd_bridge uart_cmd_bridge_checker u_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_vld (read_vld)
);

`default_nettype wire

// ==== tests/uart_cmd_bridge_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module uart_cmd_bridge_tb;

  import uart_cmd_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int ADDR_W          = CMD_WIDTH - DATA_WIDTH - 1;
  localparam int NUM_FIXED       = 6;
  localparam int NUM_ROWS        = 14;
  localparam int ROW_CYCLES      = 3 * FRAME_BITS * CLKS_PER_BIT + GAP_CYCLES;
  localparam int WATCHDOG_CYCLES = 2 * (NUM_ROWS * ROW_CYCLES + 64 * CLKS_PER_BIT);

  typedef struct packed {
    uart_cmd_t             cmd;
    logic [DATA_WIDTH-1:0] reply;     // Reply byte for reads.
    logic                  corrupt;   // Flip the reply's parity.
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  exp_err;
    logic                  hold_vld;  // Keep cmd_vld high during the command.
  } row_t;

  logic                  clk;
  logic                  rst_n;
  uart_cmd_t             cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  rx;
  logic                  tx;
  logic [DATA_WIDTH-1:0] read_data;
  logic                  read_vld;
  logic                  read_err;
  row_t                  tab [NUM_ROWS];
  logic [DATA_WIDTH-1:0] tx_bytes [$];
  int                    tx_gaps [$];
  int                    cur_row;
  int                    read_vld_count;
  int                    checks;
  int                    errors;
  integer                seed;

  uart_cmd_bridge u_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(negedge clk)
  begin
    if (read_vld === 1'b1)
      read_vld_count++;
  end

  task automatic check_bit(input string name, input logic act, input logic exp);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, act, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [DATA_WIDTH-1:0] act,
                            input logic [DATA_WIDTH-1:0] exp);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, act, exp);
    end
  endtask

  task automatic check_cmd(input string name, input uart_cmd_t act, input uart_cmd_t exp);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, act, exp);
    end
  endtask

  // Parity bit that makes data plus parity carry an odd count of ones.
  function automatic logic parity_for(input logic [DATA_WIDTH-1:0] data);
    int ones;
    ones = 0;
    for (int b = 0; b < DATA_WIDTH; b++)
      if (data[b])
        ones++;
    return (ones % 2 == 0);
  endfunction

  function automatic row_t make_row(input logic wr, input logic [ADDR_W-1:0] addr,
                                    input logic [DATA_WIDTH-1:0] low,
                                    input logic [DATA_WIDTH-1:0] reply,
                                    input logic corrupt, input logic hold);
    row_t r;
    r = '0;
    if (wr)
    begin
      r.cmd.wr.rw   = 1'b1;
      r.cmd.wr.addr = addr;
      r.cmd.wr.data = low;
    end
    else
    begin
      r.cmd.rd.rw    = 1'b0;
      r.cmd.rd.addr  = addr;
      r.cmd.rd.spare = low;    // Ignored by the bridge.
      r.reply        = reply;
      r.corrupt      = corrupt;
      r.exp_data     = reply;
      r.exp_err      = corrupt;
    end
    r.hold_vld = hold;
    return r;
  endfunction

  // Mid-bit decode of one tx frame, called at the negedge where tx is first low.
  task automatic decode_frame(output logic [DATA_WIDTH-1:0] data);
    logic par;
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    check_bit("tx start bit", tx, 1'b0);
    for (int b = 0; b < DATA_WIDTH; b++)
    begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[b] = tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    par = tx;
    check_bit("tx parity", par, parity_for(data));
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_bit("tx stop bit", tx, 1'b1);
  endtask

  task automatic send_reply(input logic [DATA_WIDTH-1:0] data, input logic corrupt);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, parity_for(data) ^ corrupt, data, 1'b0};
    for (int b = 0; b < FRAME_BITS; b++)
    begin
      rx = frame[b];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  // Remote device. Idle is counted from the stop bit's middle.
  initial
  begin : line_model
    logic [DATA_WIDTH-1:0] data;
    int                    idle;
    idle = 0;
    @(posedge rst_n);
    forever
    begin
      @(negedge clk);
      if (tx === 1'b0)
      begin
        decode_frame(data);
        tx_bytes.push_back(data);
        tx_gaps.push_back(idle - (CLKS_PER_BIT / 2 - 1));
        idle = 0;
        // Only the address byte of a read gets a reply.
        if (tx_bytes.size() == 1 && !data[DATA_WIDTH-1])
        begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          send_reply(tab[cur_row].reply, tab[cur_row].corrupt);
        end
      end
      else
        idle++;
    end
  end

  task automatic run_row(input int idx);
    row_t        r;
    logic        is_write;
    logic        done;
    logic [31:0] rnd;
    int          reads_before;
    uart_cmd_t   act;
    uart_cmd_t   exp;
    r            = tab[idx];
    is_write     = r.cmd.wr.rw;
    cur_row      = idx;
    reads_before = read_vld_count;
    @(negedge clk);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    cmd_in  = r.cmd;
    cmd_vld = 1'b1;
    done    = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      if (r.hold_vld)
      begin
        rnd    = $random(seed);    // Must be ignored while busy.
        cmd_in = rnd[CMD_WIDTH-1:0];
      end
      else
        cmd_vld = 1'b0;
      done = is_write ? (cmd_rdy === 1'b1) : (read_vld === 1'b1);
    end
    cmd_vld = 1'b0;
    if (!is_write)
    begin
      check_byte("read_data", read_data, r.exp_data);
      check_bit("read_err", read_err, r.exp_err);
      check_bit("cmd_rdy", cmd_rdy, 1'b1);
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    if (read_vld_count - reads_before != (is_write ? 0 : 1))
    begin
      errors++;
      $display("Command %0d gave %0d read_vld pulses", idx, read_vld_count - reads_before);
    end
    if (tx_bytes.size() != (is_write ? 2 : 1))
    begin
      errors++;
      $display("Command %0d sent %0d frames on tx", idx, tx_bytes.size());
    end
    else if (is_write)
    begin
      act         = '0;
      exp         = '0;
      act.wr.rw   = tx_bytes[0][DATA_WIDTH-1];
      act.wr.addr = tx_bytes[0][ADDR_W-1:0];
      exp.wr.rw   = r.cmd.wr.rw;
      exp.wr.addr = r.cmd.wr.addr;
      check_cmd("tx address byte", act, exp);
      check_byte("tx data byte", tx_bytes[1], r.cmd.wr.data);
      if (tx_gaps[1] < GAP_CYCLES)
      begin
        errors++;
        $display("Command %0d left only %0d idle cycles between bytes", idx, tx_gaps[1]);
      end
    end
    else
    begin
      act         = '0;
      exp         = '0;
      act.rd.rw   = tx_bytes[0][DATA_WIDTH-1];
      act.rd.addr = tx_bytes[0][ADDR_W-1:0];
      exp.rd.rw   = r.cmd.rd.rw;
      exp.rd.addr = r.cmd.rd.addr;
      check_cmd("tx address byte", act, exp);
    end
    tx_bytes.delete();
    tx_gaps.delete();
  endtask

  initial
  begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the bridge stopped at command %0d and never finished", cur_row);
    $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin : main
    logic [31:0] rnd;
    int          total;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    seed    = 86;
    cur_row = 0;
    checks  = 0;
    errors  = 0;
    tab[0] = make_row(1'b1, 7'h12, 8'hA5, 8'h00, 1'b0, 1'b0);
    tab[1] = make_row(1'b1, 7'h7F, 8'h00, 8'h00, 1'b0, 1'b0);
    tab[2] = make_row(1'b0, 7'h05, 8'h00, 8'h3C, 1'b0, 1'b0);
    tab[3] = make_row(1'b0, 7'h40, 8'hFF, 8'hFF, 1'b1, 1'b0);
    tab[4] = make_row(1'b1, 7'h33, 8'h81, 8'h00, 1'b0, 1'b1);
    tab[5] = make_row(1'b0, 7'h11, 8'h5A, 8'h00, 1'b0, 1'b1);
    for (int i = NUM_FIXED; i < NUM_ROWS; i++)
    begin
      rnd    = $random(seed);
      tab[i] = make_row(rnd[26], rnd[ADDR_W-1:0], rnd[15:8], rnd[23:16], rnd[24], rnd[25]);
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("tx", tx, 1'b1);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    check_bit("read_vld", read_vld, 1'b0);
    check_bit("read_err", read_err, 1'b0);
    check_byte("read_data", read_data, '0);
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);
    repeat (4 * CLKS_PER_BIT) @(negedge clk);
    if (tx_bytes.size() != 0)
    begin
      errors++;
      $display("Frames appeared on tx after the last command");
    end
    total = errors + u_dut.u_checker.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             u_dut.u_checker.fail_count);
    if (total == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_cmd_bridge.f ====
design/uart_cmd_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_cmd_ctrl.sv
design/uart_cmd_bridge.sv
tests/uart_cmd_bridge_checker.sv
tests/uart_cmd_bridge_tb.sv
